//--- hdl/argmax_tree.sv
// Finds the index of the largest activation and checks it against the one-hot label
// Index registered after one cycle, index and verdict after two
`timescale 1ns/1ps
`default_nettype none

module argmax_tree #(
	parameter int WIDTH = nn_pkg::WIDTH,
	parameter int NEURONS = nn_pkg::NEURONS,
	localparam int IDX_BITS = nn_pkg::idx_width(NEURONS)
) (
	input logic clk,
	input logic reset,
	input logic signed [WIDTH-1:0] act_i [NEURONS],
	input logic [NEURONS-1:0] label_i, // Already one cycle behind act_i
	output logic [IDX_BITS-1:0] pred_o,
	output logic correct_o
);

	localparam int LEAVES = 2 ** IDX_BITS; // Padded to a power of two

	// Heap layout, node k has children 2k and 2k+1, root is node 1
	logic signed [WIDTH-1:0] node_val [1:2*LEAVES-1];
	logic [IDX_BITS-1:0] node_pos [1:2*LEAVES-1];
	logic [IDX_BITS-1:0] idx_q;

	for (genvar i = 0; i < LEAVES; i++) begin : g_leaf
		if (i < NEURONS) begin : g_real
			assign node_val[LEAVES+i] = act_i[i];
		end else begin : g_pad
			assign node_val[LEAVES+i] = {1'b1, {(WIDTH-1){1'b0}}}; // Most negative never wins
		end
		assign node_pos[LEAVES+i] = IDX_BITS'(i);
	end

	for (genvar k = 1; k < LEAVES; k++) begin : g_node
		logic left_wins;

		assign left_wins = node_val[2*k] >= node_val[2*k+1]; // Lower index takes ties
		assign node_val[k] = left_wins ? node_val[2*k] : node_val[2*k+1];
		assign node_pos[k] = left_wins ? node_pos[2*k] : node_pos[2*k+1];
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			idx_q <= '0;
		end else begin
			idx_q <= node_pos[1];
		end
	end

	// Second stage meets the delayed label
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pred_o <= '0;
			correct_o <= 1'b0;
		end else begin
			pred_o <= idx_q;
			correct_o <= label_i[idx_q];
		end
	end

	// Padded leaves must never win against a real neuron
	a_idx_range: assert property (@(posedge clk) disable iff (reset) idx_q < NEURONS);

endmodule

`default_nettype wire

//--- hdl/delay_line.sv
// Register chain that delays any payload by DEPTH clock cycles
// All stages clear to zero on reset
`timescale 1ns/1ps
`default_nettype none

module delay_line #(
	parameter type payload_t = logic,
	parameter int DEPTH = 1
) (
	input logic clk,
	input logic reset,
	input payload_t data_i,
	output payload_t data_o
);

	payload_t stage_q [DEPTH];

	if (DEPTH < 1) begin : g_depth_check
		$error("delay_line needs a DEPTH of at least 1");
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				stage_q[i] <= '0;
			end
		end else begin
			stage_q[0] <= data_i;
			for (int i = 1; i < DEPTH; i++) begin
				stage_q[i] <= stage_q[i-1]; // Shift one stage along
			end
		end
	end

	assign data_o = stage_q[DEPTH-1];

endmodule

`default_nettype wire

//--- hdl/delta_lane.sv
// One neuron of the quadratic-cost error term, (act - label) * derivative
// Two register stages, the product is rounded and saturated back to the input format
`timescale 1ns/1ps
`default_nettype none

module delta_lane #(
	parameter int WIDTH = nn_pkg::WIDTH,
	parameter int INT_BITS = nn_pkg::INT_BITS
) (
	input logic clk,
	input logic reset,
	input logic signed [WIDTH-1:0] act_i,
	input logic signed [WIDTH-1:0] adot_i,
	input logic label_i,
	output logic signed [WIDTH-1:0] delta_o
);

	localparam int FRAC = WIDTH - INT_BITS - 1;
	localparam logic signed [WIDTH-1:0] MAX_POS = {1'b0, {(WIDTH-1){1'b1}}};
	localparam logic signed [WIDTH-1:0] MAX_NEG = {1'b1, {(WIDTH-1){1'b0}}};

	logic signed [WIDTH-1:0] label_val; // 1.0 or 0
	logic signed [WIDTH-1:0] neg_label;
	logic signed [WIDTH-1:0] sum_raw;
	logic sum_ovf;
	logic signed [WIDTH-1:0] err_d;
	logic signed [WIDTH-1:0] err_q;
	logic signed [WIDTH-1:0] adot_q;
	logic signed [2*WIDTH-1:0] prod; // Full precision, two sign bits
	logic signed [WIDTH-1:0] prod_scaled;
	logic signed [WIDTH-1:0] delta_q;

	// Label bit lands on the units position
	assign label_val = {{INT_BITS{1'b0}}, label_i, {FRAC{1'b0}}};
	assign neg_label = ~label_val + 1'b1;

	// Saturating add of the negated label
	assign sum_raw = act_i + neg_label;
	assign sum_ovf = (act_i[WIDTH-1] == neg_label[WIDTH-1]) &&
		(sum_raw[WIDTH-1] != act_i[WIDTH-1]);
	assign err_d = sum_ovf ? (sum_raw[WIDTH-1] ? MAX_POS : MAX_NEG) : sum_raw;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			err_q <= '0;
			adot_q <= '0;
		end else begin
			err_q <= err_d;
			adot_q <= adot_i; // Derivative follows its error term
		end
	end

	assign prod = err_q * adot_q;

	fixed_scaler #(
		.FROM_WIDTH(2 * WIDTH),
		.FROM_SIGN_BITS(2),
		.FROM_INT_BITS(2 * INT_BITS),
		.WIDTH(WIDTH),
		.INT_BITS(INT_BITS)
	) u_scaler (
		.value_i(prod),
		.value_o(prod_scaled)
	);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			delta_q <= '0;
		end else begin
			delta_q <= prod_scaled;
		end
	end

	assign delta_o = delta_q;

	// Unknowns on act or adot must not reach the output
	a_delta_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(delta_o));

endmodule

`default_nettype wire

//--- hdl/fixed_scaler.sv
// Combinational fixed-point format converter with round-half-up and saturation
// Input is {sign, int, frac} with FROM_SIGN_BITS sign bits, output has a single sign bit
`timescale 1ns/1ps
`default_nettype none

module fixed_scaler #(
	parameter int FROM_WIDTH = 2 * nn_pkg::WIDTH,
	parameter int FROM_SIGN_BITS = 2,
	parameter int FROM_INT_BITS = 2 * nn_pkg::INT_BITS,
	parameter int WIDTH = nn_pkg::WIDTH,
	parameter int INT_BITS = nn_pkg::INT_BITS
) (
	input logic signed [FROM_WIDTH-1:0] value_i,
	output logic signed [WIDTH-1:0] value_o
);

	localparam int FROM_FRAC = FROM_WIDTH - FROM_SIGN_BITS - FROM_INT_BITS;
	localparam int FRAC = WIDTH - INT_BITS - 1;
	localparam int FRAC_W = (FRAC > 0) ? FRAC : 1; // Spare bit when there is no fraction
	localparam int EXT_BITS = (FROM_INT_BITS > INT_BITS) ? FROM_INT_BITS : INT_BITS;
	localparam logic signed [WIDTH-1:0] MAX_POS = {1'b0, {(WIDTH-1){1'b1}}};
	localparam logic signed [WIDTH-1:0] MAX_NEG = {1'b1, {(WIDTH-1){1'b0}}};
	localparam int INT_MAX = 2 ** INT_BITS - 1;
	localparam int INT_MIN = -(2 ** INT_BITS);

	logic sign_clash; // Sign bits disagree, only on most-negative squared
	logic signed [FROM_INT_BITS:0] in_int; // Lowest sign bit plus integer field
	logic signed [EXT_BITS:0] int_ext; // Sign extended for the range compare
	logic [FRAC_W-1:0] out_frac;
	logic round_bit; // MSB of the dropped fraction
	logic [INT_BITS+FRAC_W:0] joined;
	logic signed [WIDTH-1:0] kept; // Value before rounding
	logic in_range;

	assign sign_clash = value_i[FROM_WIDTH-1] != value_i[FROM_WIDTH-FROM_SIGN_BITS];
	assign in_int = value_i[FROM_WIDTH-FROM_SIGN_BITS -: FROM_INT_BITS+1];
	assign int_ext = in_int;

	// Fraction field, truncated or zero padded
	generate
		if (FROM_FRAC >= FRAC) begin : g_frac_narrow
			if (FRAC > 0) begin : g_keep
				assign out_frac = value_i[FROM_FRAC-1 -: FRAC_W];
			end else begin : g_none
				assign out_frac = '0;
			end
			if (FROM_FRAC > FRAC) begin : g_round
				assign round_bit = value_i[FROM_FRAC-FRAC-1];
			end else begin : g_exact
				assign round_bit = 1'b0; // Nothing dropped
			end
		end else begin : g_frac_widen
			if (FROM_FRAC > 0) begin : g_pad
				assign out_frac = {value_i[FROM_FRAC-1:0], {(FRAC-FROM_FRAC){1'b0}}};
			end else begin : g_zero
				assign out_frac = '0;
			end
			assign round_bit = 1'b0;
		end
	endgenerate

	// Low integer bits with sign on top, spare fraction bit falls off the bottom
	assign joined = {int_ext[INT_BITS:0], out_frac};

	always_comb begin
		in_range = 1'b0;
		if (sign_clash) begin
			kept = MAX_POS;
		end else if (int_ext > INT_MAX) begin
			kept = MAX_POS; // Positive overflow
		end else if (int_ext < INT_MIN) begin
			kept = MAX_NEG; // Negative overflow
		end else begin
			kept = joined[INT_BITS+FRAC_W -: WIDTH];
			in_range = 1'b1;
		end
	end

	// Round half up, but never wrap past the largest positive value
	assign value_o = (in_range && round_bit && kept != MAX_POS) ? kept + 1'b1 : kept;

endmodule

`default_nettype wire

//--- hdl/nn_pkg.sv
// Fixed-point format and output-layer size shared by the whole datapath
// Modules use these as parameter defaults, and the top level may override them
`default_nettype none

package nn_pkg;

	localparam int WIDTH = 12; // Total bits of one value
	localparam int INT_BITS = 3; // Integer bits, sign bit not counted
	localparam int NEURONS = 4; // Output neurons (Z)

	// Index width for n items, never below one bit
	function automatic int idx_width(input int n);
		return (n > 1) ? $clog2(n) : 1;
	endfunction

	localparam int IDX_BITS = idx_width(NEURONS);

	// One activation, derivative or error term
	typedef logic signed [WIDTH-1:0] fixed_t;

endpackage

`default_nettype wire

//--- hdl/output_layer_eval.sv
// Output stage of the network, per-neuron error terms plus argmax and label verdict
// Accepts one sample per cycle, results follow valid_i by exactly two cycles
`timescale 1ns/1ps
`default_nettype none

module output_layer_eval #(
	parameter int WIDTH = nn_pkg::WIDTH,
	parameter int INT_BITS = nn_pkg::INT_BITS,
	parameter int NEURONS = nn_pkg::NEURONS,
	localparam int IDX_BITS = nn_pkg::idx_width(NEURONS)
) (
	input logic clk,
	input logic reset,
	input logic valid_i,
	input logic signed [WIDTH-1:0] act_i [NEURONS],
	input logic signed [WIDTH-1:0] adot_i [NEURONS],
	input logic [NEURONS-1:0] label_i, // One-hot
	output logic valid_o,
	output logic signed [WIDTH-1:0] delta_o [NEURONS],
	output logic [IDX_BITS-1:0] pred_o,
	output logic correct_o
);

	logic [NEURONS-1:0] label_d1; // Label lined up with the registered index

	for (genvar i = 0; i < NEURONS; i++) begin : g_lane
		delta_lane #(
			.WIDTH(WIDTH),
			.INT_BITS(INT_BITS)
		) u_lane (
			.clk(clk),
			.reset(reset),
			.act_i(act_i[i]),
			.adot_i(adot_i[i]),
			.label_i(label_i[i]),
			.delta_o(delta_o[i])
		);
	end

	argmax_tree #(
		.WIDTH(WIDTH),
		.NEURONS(NEURONS)
	) u_argmax (
		.clk(clk),
		.reset(reset),
		.act_i(act_i),
		.label_i(label_d1),
		.pred_o(pred_o),
		.correct_o(correct_o)
	);

	// Valid matches the two-stage datapath
	delay_line #(
		.payload_t(logic),
		.DEPTH(2)
	) u_valid_dly (
		.clk(clk),
		.reset(reset),
		.data_i(valid_i),
		.data_o(valid_o)
	);

	delay_line #(
		.payload_t(logic [NEURONS-1:0]),
		.DEPTH(1)
	) u_label_dly (
		.clk(clk),
		.reset(reset),
		.data_i(label_i),
		.data_o(label_d1)
	);

endmodule

`default_nettype wire

//--- tb.f
hdl/nn_pkg.sv
hdl/fixed_scaler.sv
hdl/delta_lane.sv
hdl/argmax_tree.sv
hdl/delay_line.sv
hdl/output_layer_eval.sv
test/output_layer_eval_tb.sv

//--- test/output_layer_eval_tb.sv
// Self-checking testbench for the output stage, seeded random and directed samples
// A model in the testbench predicts every result, the monitor checks it two cycles later
`timescale 1ns/1ps
`default_nettype none

module output_layer_eval_tb;

	import nn_pkg::*;

	localparam int FRAC = WIDTH - INT_BITS - 1;
	localparam logic signed [WIDTH-1:0] MAX_POS = {1'b0, {(WIDTH-1){1'b1}}};
	localparam logic signed [WIDTH-1:0] MAX_NEG = {1'b1, {(WIDTH-1){1'b0}}};
	localparam int RESET_CYCLES = 4;
	localparam int RANDOM_CYCLES = 400;
	localparam int DIRECTED_CYCLES = 2 + 2 + 16; // Saturation, rounding, ties
	localparam int B2B_CYCLES = 50;
	localparam int DRAIN_CYCLES = 5 * 6; // Five drains, bounded wait plus one
	localparam int TIMEOUT = RESET_CYCLES + 1 + RANDOM_CYCLES + DIRECTED_CYCLES + B2B_CYCLES +
		DRAIN_CYCLES + 50;

	logic clk = 1'b0; // Starts low without an edge at time zero
	logic reset;
	logic valid_i;
	fixed_t act_i [NEURONS];
	fixed_t adot_i [NEURONS];
	logic [NEURONS-1:0] label_i;
	logic valid_o;
	fixed_t delta_o [NEURONS];
	logic [IDX_BITS-1:0] pred_o;
	logic correct_o;

	integer seed;
	int cycles = 0; // Rising edges seen so far
	int sent = 0;
	int checked = 0;

	// Expected results, one entry per accepted sample
	logic [NEURONS*WIDTH-1:0] delta_q [$];
	logic [IDX_BITS-1:0] pred_q [$];
	logic correct_q [$];
	string name_q [$];
	int due_q [$]; // Cycle at which the result must show up

	output_layer_eval #(
		.WIDTH(WIDTH),
		.INT_BITS(INT_BITS),
		.NEURONS(NEURONS)
	) uut (
		.clk(clk),
		.reset(reset),
		.valid_i(valid_i),
		.act_i(act_i),
		.adot_i(adot_i),
		.label_i(label_i),
		.valid_o(valid_o),
		.delta_o(delta_o),
		.pred_o(pred_o),
		.correct_o(correct_o)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Timeout: run went past %0d cycles", TIMEOUT);
			$display("Regression failed");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	task automatic compare(input string name, input logic signed [63:0] expected,
		input logic signed [63:0] actual);
		if (expected !== actual) begin
			$display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
			$display("Regression failed");
			$fatal(1, "Stopped at the first wrong value");
		end
	endtask

	// act - label with saturation, label is 1.0 or 0
	function automatic logic signed [WIDTH-1:0] saturate_diff(input logic signed [WIDTH-1:0] a,
		input logic lab);
		int diff;
		diff = int'(a) - (lab ? (1 << FRAC) : 0);
		if (diff > MAX_POS) begin
			return MAX_POS;
		end else if (diff < MAX_NEG) begin
			return MAX_NEG;
		end
		return WIDTH'(diff);
	endfunction

	// Full-precision product, saturated, then rounded half up on the top dropped bit
	function automatic logic signed [WIDTH-1:0] scaled_product(input logic signed [WIDTH-1:0] e,
		input logic signed [WIDTH-1:0] d);
		logic signed [2*WIDTH-1:0] p;
		longint int_part;
		longint kept;
		p = e * d;
		if (p[2*WIDTH-1] != p[2*WIDTH-2]) begin
			return MAX_POS; // Most negative squared
		end
		int_part = p >>> (2 * FRAC);
		if (int_part > 2 ** INT_BITS - 1) begin
			return MAX_POS;
		end else if (int_part < -(2 ** INT_BITS)) begin
			return MAX_NEG;
		end
		kept = p >>> FRAC;
		if (p[FRAC-1] && kept != MAX_POS) begin
			kept = kept + 1;
		end
		return WIDTH'(kept);
	endfunction

	function automatic int winner_index();
		int win;
		win = 0;
		for (int i = 1; i < NEURONS; i++) begin
			if (act_i[i] > act_i[win]) begin
				win = i; // Strictly greater, so ties stay with the lower index
			end
		end
		return win;
	endfunction

	// Drive valid for one cycle and record the model's answer for this sample
	task automatic apply(input string name, input logic v);
		logic [NEURONS*WIDTH-1:0] deltas;
		int win;
		valid_i = v;
		if (v) begin
			for (int i = 0; i < NEURONS; i++) begin
				deltas[i*WIDTH +: WIDTH] = scaled_product(saturate_diff(act_i[i], label_i[i]),
					adot_i[i]);
			end
			win = winner_index();
			delta_q.push_back(deltas);
			pred_q.push_back(IDX_BITS'(win));
			correct_q.push_back(label_i[win]);
			name_q.push_back(name);
			due_q.push_back(cycles + 2); // Captured next edge, out on the edge after
			sent++;
		end
		@(posedge clk);
		#1;
	endtask

	task automatic randomize_inputs();
		logic signed [WIDTH-1:0] raw;
		for (int i = 0; i < NEURONS; i++) begin
			raw = WIDTH'($random(seed));
			act_i[i] = raw >>> ($unsigned($random(seed)) % 6); // Smaller values hit rounding
			raw = WIDTH'($random(seed));
			adot_i[i] = raw >>> ($unsigned($random(seed)) % 6);
		end
		label_i = NEURONS'(1) << ($unsigned($random(seed)) % NEURONS);
	endtask

	task automatic set_lane(input int i, input int a, input int d);
		act_i[i] = WIDTH'(a);
		adot_i[i] = WIDTH'(d);
	endtask

	// Let the pipeline empty, bounded so a lost sample cannot stall the run
	task automatic drain();
		valid_i = 1'b0;
		for (int n = 0; n < 4 && delta_q.size() != 0; n++) begin
			@(posedge clk);
		end
		@(posedge clk);
		#1;
	endtask

	always @(negedge clk) begin : monitor
		logic [NEURONS*WIDTH-1:0] exp_delta;
		string name;
		if (reset) begin
			compare("reset valid_o", 0, valid_o);
			compare("reset correct_o", 0, correct_o);
		end else if (valid_o) begin
			if (delta_q.size() == 0) begin
				$display("Error: valid_o went high with no sample in flight");
				$display("Regression failed");
				$fatal(1, "Unexpected output");
			end else begin
				exp_delta = delta_q.pop_front();
				name = name_q.pop_front();
				compare({name, " latency"}, due_q.pop_front(), cycles);
				for (int i = 0; i < NEURONS; i++) begin
					compare($sformatf("%s delta[%0d]", name, i),
						$signed(exp_delta[i*WIDTH +: WIDTH]), delta_o[i]);
				end
				compare({name, " pred_o"}, pred_q.pop_front(), pred_o);
				compare({name, " correct_o"}, correct_q.pop_front(), correct_o);
				checked++;
			end
		end
	end

	initial begin
		seed = 32'hfedc_3ba2;
		reset = 1'b1;
		valid_i = 1'b0;
		label_i = '0;
		for (int i = 0; i < NEURONS; i++) begin
			set_lane(i, 0, 0);
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		compare("after reset valid_o", 0, valid_o);
		compare("after reset correct_o", 0, correct_o);
		@(posedge clk);
		#1;

		for (int n = 0; n < RANDOM_CYCLES; n++) begin
			randomize_inputs();
			apply("random stream", ($unsigned($random(seed)) % 10) < 7); // About 70% valid
		end
		drain();

		// Subtraction saturates, most negative squared, overflow both ways
		set_lane(0, -2048, 256);
		set_lane(1, -2048, -2048);
		set_lane(2, 2047, 2047);
		set_lane(3, 2047, -2048);
		label_i = 4'b0001;
		apply("saturation", 1'b1);
		set_lane(0, 2047, 2047);
		set_lane(1, -2048, 1024);
		set_lane(2, -1900, 1800);
		label_i = 4'b0010;
		apply("saturation", 1'b1);
		drain();

		// Half a unit rounds up, a product on the largest value stays put
		set_lane(0, 1, 128);
		set_lane(1, 3, 128);
		set_lane(2, 255, 128); // -1 after the label
		set_lane(3, 1365, 384);
		label_i = 4'b0100;
		apply("rounding", 1'b1);
		set_lane(0, 1365, 384);
		set_lane(1, 2047, 256);
		set_lane(2, -3, 128);
		set_lane(3, 261, 200);
		label_i = 4'b1000;
		apply("rounding", 1'b1);
		drain();

		for (int t = 0; t < 4; t++) begin
			for (int l = 0; l < NEURONS; l++) begin
				case (t)
					0: begin
						for (int i = 0; i < NEURONS; i++) begin
							set_lane(i, 100, 256);
						end
					end
					1: begin
						set_lane(0, 0, 256);
						set_lane(1, 500, 256);
						set_lane(2, -7, 256);
						set_lane(3, 500, 256);
					end
					2: begin
						for (int i = 0; i < NEURONS; i++) begin
							set_lane(i, -2048, 256);
						end
					end
					default: begin
						set_lane(0, 2046, 256);
						set_lane(1, -1, 256);
						set_lane(2, 2047, 256);
						set_lane(3, 2047, 256);
					end
				endcase
				label_i = NEURONS'(1) << l; // Verdict from every label position
				apply("argmax ties", 1'b1);
			end
		end
		drain();

		for (int n = 0; n < B2B_CYCLES; n++) begin
			randomize_inputs();
			apply("back to back", 1'b1);
		end
		drain();

		if (checked == sent && delta_q.size() == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("Error: %0d of %0d samples never reached the outputs", sent - checked, sent);
			$display("Regression failed");
			$fatal(1, "Samples lost");
		end
	end

endmodule

`default_nettype wire
